/* tcm_defines.svh */
// ======================================================================
// Sizing macros for the data memory subsystem, shared by package and RTL
// ======================================================================
`ifndef TCM_DEFINES_SVH
`define TCM_DEFINES_SVH

// Words in the shared SRAM
`define TCM_DEPTH 2048

// Word address bits, must cover TCM_DEPTH exactly
`define TCM_ADDR_W 11

// Byte lanes per data word
`define TCM_LANES 4

// Bits per byte lane
`define TCM_LANE_W 8

// Request queue depth per port
// Also the credits a requester starts with after reset
`define TCM_CREDITS 4

`endif

/* tcm_pkg.sv */
// ======================================================================
// Shared types of the data memory subsystem, referenced by scoped name
// ======================================================================
`include "tcm_defines.svh"

package tcm_pkg;

  // Word address into the SRAM
  typedef logic [`TCM_ADDR_W-1:0] addr_t;

  // One data word, all lanes
  typedef logic [`TCM_LANES*`TCM_LANE_W-1:0] data_t;

  // Byte enables, active high at the request ports
  typedef logic [`TCM_LANES-1:0] be_t;

  // Per-bit write mask, active low at the SRAM
  typedef logic [`TCM_LANES*`TCM_LANE_W-1:0] wmask_t;

  // Queue occupancy, 0 up to TCM_CREDITS inclusive
  typedef logic [$clog2(`TCM_CREDITS+1)-1:0] credit_t;

  // Round-robin arbiter state
  // Names the port that wins the next tie
  typedef enum logic {
    ARB_PREFER0,
    ARB_PREFER1
  } arb_state_t;

endpackage

/* fpga_ram.sv */
// ======================================================================
// Generic single-port RAM slice with registered read, one per byte lane
// ======================================================================
module fpga_ram #(
  parameter int width     = 8,
  parameter int addr_bits = 11
) (
  input  logic                 CLK,
  input  logic [addr_bits-1:0] addr,
  input  logic [width-1:0]     din,
  input  logic                 we,
  output logic [width-1:0]     dout
);

  // Full power-of-two storage
  logic [width-1:0] mem [1<<addr_bits];

  // Write port
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= din;
    end
  end

  // Registered read, new data on a write cycle
  // Same address every cycle keeps dout steady
  always_ff @(posedge CLK) begin
    if (we) begin
      dout <= din;
    end else begin
      dout <= mem[addr];
    end
  end

endmodule

/* ct_f_spsram_2048x32.sv */
// ======================================================================
// 2048x32 single-port SRAM from four byte slices, active-low controls;
// q holds its value while the chip is deselected
// ======================================================================
`include "tcm_defines.svh"

module ct_f_spsram_2048x32 (
  input  logic            CLK,
  input  tcm_pkg::addr_t  a,
  input  logic            cen,
  input  tcm_pkg::data_t  d,
  input  logic            gwen,
  input  tcm_pkg::wmask_t wen,
  output tcm_pkg::data_t  q
);

  // Address of the last enabled access
  tcm_pkg::addr_t addr_hold;
  // Address presented to every slice
  tcm_pkg::addr_t ram_addr;

  // Geometry sanity at elaboration
  if ((1 << `TCM_ADDR_W) != `TCM_DEPTH) begin : g_depth_check
    $error("SRAM address width does not match depth");
  end

  // Capture address on each chip access
  always_ff @(posedge CLK) begin
    if (!cen) begin
      addr_hold <= a;
    end
  end

  // Deselected, so slices keep re-reading the last word
  assign ram_addr = cen ? addr_hold : a;

  genvar lane;
  generate
    for (lane = 0; lane < `TCM_LANES; lane++) begin : g_lane
      logic                   lane_we;
      logic [`TCM_LANE_W-1:0] lane_mask;

      assign lane_mask = wen[lane*`TCM_LANE_W +: `TCM_LANE_W];

      // Lane writes when selected, globally enabled and mask MSB low
      assign lane_we = !cen && !gwen && !lane_mask[`TCM_LANE_W-1];

      fpga_ram #(
        .width    (`TCM_LANE_W),
        .addr_bits(`TCM_ADDR_W)
      ) ram_inst (
        .CLK (CLK),
        .addr(ram_addr),
        .din (d[lane*`TCM_LANE_W +: `TCM_LANE_W]),
        .we  (lane_we),
        .dout(q[lane*`TCM_LANE_W +: `TCM_LANE_W])
      );

      // Slices store whole bytes only
      // Mask from the arbiter must be all-on or all-off per lane
      a_lane_mask_uniform : assert property (
        @(posedge CLK) (!cen && !gwen) |-> ((&lane_mask) || !(|lane_mask))
      ) else $error("write mask not uniform within lane %0d", lane);
    end
  endgenerate

endmodule

/* tcm_req_port.sv */
// ======================================================================
// Requester front end: credited request queue feeding the arbiter,
// with one credit returned for each entry sent to the SRAM
// ======================================================================
`include "tcm_defines.svh"

module tcm_req_port (
  input  logic           CLK,
  input  logic           rst,
  input  logic           req_valid,
  input  logic           req_write,
  input  tcm_pkg::addr_t req_addr,
  input  tcm_pkg::be_t   req_be,
  input  tcm_pkg::data_t req_wdata,
  input  logic           grant,
  output logic           credit,
  output logic           has_req,
  output logic           head_write,
  output tcm_pkg::addr_t head_addr,
  output tcm_pkg::be_t   head_be,
  output tcm_pkg::data_t head_wdata
);

  localparam int DEPTH = `TCM_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Queue control
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  tcm_pkg::credit_t count_q;

  // Queue payload
  logic             q_write [DEPTH];
  tcm_pkg::addr_t   q_addr  [DEPTH];
  tcm_pkg::be_t     q_be    [DEPTH];
  tcm_pkg::data_t   q_wdata [DEPTH];

  logic enq;
  logic deq;

  // No ready, every valid cycle is taken
  assign enq = req_valid;
  // Head leaves on the edge ending the grant cycle
  assign deq = grant && has_req;

  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at DEPTH, not at a power of two
      if (enq) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (deq) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({enq, deq})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload write, no reset needed
  always_ff @(posedge CLK) begin
    if (enq) begin
      q_write[wr_ptr_q] <= req_write;
      q_addr[wr_ptr_q]  <= req_addr;
      q_be[wr_ptr_q]    <= req_be;
      q_wdata[wr_ptr_q] <= req_wdata;
    end
  end

  assign has_req    = (count_q != '0);
  assign head_write = q_write[rd_ptr_q];
  assign head_addr  = q_addr[rd_ptr_q];
  assign head_be    = q_be[rd_ptr_q];
  assign head_wdata = q_wdata[rd_ptr_q];

  // Credit goes back in the grant cycle itself
  assign credit = deq;

  // Requester spent a credit it did not hold
  a_no_enq_full : assert property (
    @(posedge CLK) disable iff (rst) req_valid |-> (count_q != tcm_pkg::credit_t'(DEPTH))
  ) else $error("request arrived with queue full");

  // Arbiter granted an idle port
  a_no_grant_empty : assert property (
    @(posedge CLK) disable iff (rst) grant |-> has_req
  ) else $error("grant arrived with queue empty");

endmodule

/* tcm_arbiter.sv */
// ======================================================================
// Round-robin arbiter between two port queues; drives the SRAM controls
// and steers read data back to the port that issued the read
// ======================================================================
`include "tcm_defines.svh"

module tcm_arbiter (
  input  logic            CLK,
  input  logic            rst,
  input  logic            has_req0,
  input  logic            has_req1,
  input  logic            write0,
  input  logic            write1,
  input  tcm_pkg::addr_t  addr0,
  input  tcm_pkg::addr_t  addr1,
  input  tcm_pkg::be_t    be0,
  input  tcm_pkg::be_t    be1,
  input  tcm_pkg::data_t  wdata0,
  input  tcm_pkg::data_t  wdata1,
  output logic            grant0,
  output logic            grant1,
  output logic            cen,
  output logic            gwen,
  output tcm_pkg::addr_t  a,
  output tcm_pkg::wmask_t wen,
  output tcm_pkg::data_t  d,
  input  tcm_pkg::data_t  q,
  output logic            rsp_valid0,
  output logic            rsp_valid1,
  output tcm_pkg::data_t  rsp_rdata
);

  tcm_pkg::arb_state_t state_q;
  // High when port 1 owns the SRAM this cycle
  logic                sel;
  tcm_pkg::be_t        be_sel;
  // Read issued last cycle, and by which port
  logic                rd_vld_q;
  logic                rd_owner_q;

  // Lone requester always wins, ties go by state
  assign grant0 = has_req0 && (!has_req1 || (state_q == tcm_pkg::ARB_PREFER0));
  assign grant1 = has_req1 && (!has_req0 || (state_q == tcm_pkg::ARB_PREFER1));
  assign sel    = grant1;

  // Granted head drives the SRAM
  assign cen    = !(grant0 || grant1);
  assign gwen   = !(sel ? write1 : write0);
  assign a      = sel ? addr1 : addr0;
  assign d      = sel ? wdata1 : wdata0;
  assign be_sel = sel ? be1 : be0;

  // Byte enable to active-low bit mask
  always_comb begin
    for (int lane = 0; lane < `TCM_LANES; lane++) begin
      wen[lane*`TCM_LANE_W +: `TCM_LANE_W] = {`TCM_LANE_W{~be_sel[lane]}};
    end
  end

  // Preference moves to the other port after each grant
  always_ff @(posedge CLK) begin
    if (rst) begin
      state_q <= tcm_pkg::ARB_PREFER0;
    end else if (grant0) begin
      state_q <= tcm_pkg::ARB_PREFER1;
    end else if (grant1) begin
      state_q <= tcm_pkg::ARB_PREFER0;
    end
  end

  // Read tag lines up with q one cycle after the access
  always_ff @(posedge CLK) begin
    if (rst) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= !cen && gwen;
    end
  end

  always_ff @(posedge CLK) begin
    if (!cen) begin
      rd_owner_q <= sel;
    end
  end

  assign rsp_valid0 = rd_vld_q && !rd_owner_q;
  assign rsp_valid1 = rd_vld_q && rd_owner_q;
  // Shared bus, valid qualifies it per port
  assign rsp_rdata  = q;

  a_grant_onehot : assert property (
    @(posedge CLK) disable iff (rst) !(grant0 && grant1)
  ) else $error("both ports granted in one cycle");

  // Under contention the other port wins next
  a_alternate0 : assert property (
    @(posedge CLK) disable iff (rst) (grant0 && has_req1) |=> grant1
  ) else $error("port 1 starved after port 0 grant");

  a_alternate1 : assert property (
    @(posedge CLK) disable iff (rst) (grant1 && has_req0) |=> grant0
  ) else $error("port 0 starved after port 1 grant");

endmodule

/* tcm_top.sv */
// ======================================================================
// Data memory subsystem top: two credited request ports share one SRAM
// ======================================================================
module tcm_top (
  input  logic           CLK,
  input  logic           rst,
  // Requester 0
  input  logic           p0_req_valid,
  input  logic           p0_req_write,
  input  tcm_pkg::addr_t p0_req_addr,
  input  tcm_pkg::be_t   p0_req_be,
  input  tcm_pkg::data_t p0_req_wdata,
  output logic           p0_credit,
  output logic           p0_rsp_valid,
  output tcm_pkg::data_t p0_rsp_rdata,
  // Requester 1
  input  logic           p1_req_valid,
  input  logic           p1_req_write,
  input  tcm_pkg::addr_t p1_req_addr,
  input  tcm_pkg::be_t   p1_req_be,
  input  tcm_pkg::data_t p1_req_wdata,
  output logic           p1_credit,
  output logic           p1_rsp_valid,
  output tcm_pkg::data_t p1_rsp_rdata
);

  // Port 0 queue head
  logic            has_req0;
  logic            head_write0;
  tcm_pkg::addr_t  head_addr0;
  tcm_pkg::be_t    head_be0;
  tcm_pkg::data_t  head_wdata0;
  logic            grant0;
  // Port 1 queue head
  logic            has_req1;
  logic            head_write1;
  tcm_pkg::addr_t  head_addr1;
  tcm_pkg::be_t    head_be1;
  tcm_pkg::data_t  head_wdata1;
  logic            grant1;
  // SRAM side
  logic            sram_cen;
  logic            sram_gwen;
  tcm_pkg::addr_t  sram_a;
  tcm_pkg::wmask_t sram_wen;
  tcm_pkg::data_t  sram_d;
  tcm_pkg::data_t  sram_q;
  tcm_pkg::data_t  rsp_rdata;

  tcm_req_port port0_inst (
    .CLK(CLK), .rst(rst),
    .req_valid(p0_req_valid), .req_write(p0_req_write), .req_addr(p0_req_addr),
    .req_be(p0_req_be), .req_wdata(p0_req_wdata),
    .grant(grant0), .credit(p0_credit), .has_req(has_req0),
    .head_write(head_write0), .head_addr(head_addr0),
    .head_be(head_be0), .head_wdata(head_wdata0)
  );

  tcm_req_port port1_inst (
    .CLK(CLK), .rst(rst),
    .req_valid(p1_req_valid), .req_write(p1_req_write), .req_addr(p1_req_addr),
    .req_be(p1_req_be), .req_wdata(p1_req_wdata),
    .grant(grant1), .credit(p1_credit), .has_req(has_req1),
    .head_write(head_write1), .head_addr(head_addr1),
    .head_be(head_be1), .head_wdata(head_wdata1)
  );

  tcm_arbiter arbiter_inst (
    .CLK(CLK), .rst(rst),
    .has_req0(has_req0), .has_req1(has_req1),
    .write0(head_write0), .write1(head_write1),
    .addr0(head_addr0), .addr1(head_addr1),
    .be0(head_be0), .be1(head_be1),
    .wdata0(head_wdata0), .wdata1(head_wdata1),
    .grant0(grant0), .grant1(grant1),
    .cen(sram_cen), .gwen(sram_gwen), .a(sram_a), .wen(sram_wen), .d(sram_d),
    .q(sram_q),
    .rsp_valid0(p0_rsp_valid), .rsp_valid1(p1_rsp_valid), .rsp_rdata(rsp_rdata)
  );

  ct_f_spsram_2048x32 sram_inst (
    .CLK(CLK), .a(sram_a), .cen(sram_cen), .d(sram_d),
    .gwen(sram_gwen), .wen(sram_wen), .q(sram_q)
  );

  // One read bus fans out to both requesters
  assign p0_rsp_rdata = rsp_rdata;
  assign p1_rsp_rdata = rsp_rdata;

endmodule

/* tcm_tb.sv */
// ======================================================================
// Testbench for the data memory subsystem: credited traffic on both
// ports, checked against a reference memory model
// ======================================================================
`include "tcm_defines.svh"

module tcm_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD    = 40;
  localparam int N_RAND    = 100;
  localparam int TOTAL_REQ = 16 + 24 + 2 * N_RAND + 2;
  localparam int HALF      = `TCM_DEPTH / 2;
  // Upper bound on the cycles a full queue pair needs to empty
  localparam int DRAIN_CYCLES = 100;

  logic           CLK;
  logic           rst;
  logic           p0_req_valid, p0_req_write, p1_req_valid, p1_req_write;
  tcm_pkg::addr_t p0_req_addr, p1_req_addr;
  tcm_pkg::be_t   p0_req_be, p1_req_be;
  tcm_pkg::data_t p0_req_wdata, p1_req_wdata;
  logic           p0_credit, p0_rsp_valid, p1_credit, p1_rsp_valid;
  tcm_pkg::data_t p0_rsp_rdata, p1_rsp_rdata;

  // Model state
  tcm_pkg::data_t ref_mem [`TCM_DEPTH];
  logic           written [`TCM_DEPTH];
  tcm_pkg::data_t exp_rd0 [$];
  tcm_pkg::data_t exp_rd1 [$];
  int             credits [2];
  logic [31:0]    rng [2];
  int             credit_events;
  int             rsp_events;
  tcm_pkg::addr_t addrs [8];

  tcm_top tcm_top_inst (
    .CLK(CLK), .rst(rst),
    .p0_req_valid(p0_req_valid), .p0_req_write(p0_req_write), .p0_req_addr(p0_req_addr),
    .p0_req_be(p0_req_be), .p0_req_wdata(p0_req_wdata),
    .p0_credit(p0_credit), .p0_rsp_valid(p0_rsp_valid), .p0_rsp_rdata(p0_rsp_rdata),
    .p1_req_valid(p1_req_valid), .p1_req_write(p1_req_write), .p1_req_addr(p1_req_addr),
    .p1_req_be(p1_req_be), .p1_req_wdata(p1_req_wdata),
    .p1_credit(p1_credit), .p1_rsp_valid(p1_rsp_valid), .p1_rsp_rdata(p1_rsp_rdata)
  );

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Numerical Recipes constants
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected word after a byte-masked write
  function automatic tcm_pkg::data_t ref_merge(input tcm_pkg::data_t old,
                                               input tcm_pkg::data_t wdata,
                                               input tcm_pkg::be_t be);
    tcm_pkg::data_t res;
    res = old;
    for (int i = 0; i < `TCM_LANES; i++) begin
      if (be[i]) res[i*`TCM_LANE_W +: `TCM_LANE_W] = wdata[i*`TCM_LANE_W +: `TCM_LANE_W];
    end
    return res;
  endfunction

  task automatic stop_on_error();
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic fail_run(input string what);
    $display("ERROR at %0t: %s", $time, what);
    stop_on_error();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic drive_port(input int port, input logic valid, input logic write,
                            input tcm_pkg::addr_t addr, input tcm_pkg::be_t be,
                            input tcm_pkg::data_t wdata);
    if (port == 0) begin
      p0_req_valid = valid;
      p0_req_write = write;
      p0_req_addr  = addr;
      p0_req_be    = be;
      p0_req_wdata = wdata;
    end else begin
      p1_req_valid = valid;
      p1_req_write = write;
      p1_req_addr  = addr;
      p1_req_be    = be;
      p1_req_wdata = wdata;
    end
  endtask

  // Called at a falling edge, returns one falling edge after the request
  task automatic issue(input int port, input logic write, input tcm_pkg::addr_t addr,
                       input tcm_pkg::be_t be, input tcm_pkg::data_t wdata);
    while (credits[port] == 0) begin
      drive_port(port, 1'b0, 1'b0, '0, '0, '0);
      @(negedge CLK);
    end
    drive_port(port, 1'b1, write, addr, be, wdata);
    credits[port]--;
    // Model follows issue order, port queues keep it
    if (write) begin
      ref_mem[addr] = ref_merge(ref_mem[addr], wdata, be);
      written[addr] = 1'b1;
    end else if (port == 0) begin
      exp_rd0.push_back(ref_mem[addr]);
    end else begin
      exp_rd1.push_back(ref_mem[addr]);
    end
    @(negedge CLK);
    drive_port(port, 1'b0, 1'b0, '0, '0, '0);
  endtask

  // 32-word window per port, one half each
  task automatic random_traffic(input int port);
    logic [31:0]    r;
    tcm_pkg::addr_t addr;
    tcm_pkg::data_t wd;
    logic           wr;
    for (int i = 0; i < N_RAND; i++) begin
      rng[port] = lcg_next(rng[port]);
      r         = rng[port];
      rng[port] = lcg_next(rng[port]);
      wd        = rng[port];
      addr      = tcm_pkg::addr_t'(port * HALF) + tcm_pkg::addr_t'(r[15:11]);
      // Unwritten word gets a full write first
      wr        = r[31] || !written[addr];
      issue(port, wr, addr, written[addr] ? r[27:24] : 4'hF, wd);
    end
  endtask

  // Every credit and every read must come back within the drain window
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((credits[0] != `TCM_CREDITS || credits[1] != `TCM_CREDITS ||
            exp_rd0.size() != 0 || exp_rd1.size() != 0) && cycles < DRAIN_CYCLES) begin
      @(negedge CLK);
      cycles++;
    end
    check_value("p0 credits", credits[0], `TCM_CREDITS);
    check_value("p1 credits", credits[1], `TCM_CREDITS);
    check_value("p0 reads outstanding", exp_rd0.size(), 0);
    check_value("p1 reads outstanding", exp_rd1.size(), 0);
  endtask

  // Credit return and response compare
  always @(posedge CLK) begin
    if (!rst) begin
      if (p0_credit === 1'b1) begin
        credits[0]++;
        credit_events++;
      end
      if (p1_credit === 1'b1) begin
        credits[1]++;
        credit_events++;
      end
      if (credits[0] > `TCM_CREDITS || credits[1] > `TCM_CREDITS)
        fail_run("a port returned more credits than the requester spent");
      if (p0_rsp_valid === 1'b1) begin
        rsp_events++;
        if (exp_rd0.size() == 0) fail_run("port 0 responded with no read outstanding");
        else check_value("p0_rsp_rdata", p0_rsp_rdata, exp_rd0.pop_front());
      end
      if (p1_rsp_valid === 1'b1) begin
        rsp_events++;
        if (exp_rd1.size() == 0) fail_run("port 1 responded with no read outstanding");
        else check_value("p1_rsp_rdata", p1_rsp_rdata, exp_rd1.pop_front());
      end
    end
  end

  // Watchdog
  initial begin
    #((40 * TOTAL_REQ + 1000) * PERIOD);
    fail_run("timeout, the test sequence did not finish in time");
  end

  initial begin
    rst = 1'b1;
    drive_port(0, 1'b0, 1'b0, '0, '0, '0);
    drive_port(1, 1'b0, 1'b0, '0, '0, '0);
    credits[0]    = `TCM_CREDITS;
    credits[1]    = `TCM_CREDITS;
    credit_events = 0;
    rsp_events    = 0;
    rng[0]        = 32'h844a3505;
    rng[1]        = 32'h844a3505 ^ 32'h5a5a5a5a;
    for (int i = 0; i < `TCM_DEPTH; i++) written[i] = 1'b0;
    repeat (5) @(negedge CLK);
    rst = 1'b0;

    // Idle after reset, nothing may come out
    repeat (10) @(negedge CLK);
    check_value("credit_events", credit_events, 0);
    check_value("rsp_events", rsp_events, 0);

    // Full words on port 0, lower half
    for (int i = 0; i < 8; i++) begin
      rng[0]   = lcg_next(rng[0]);
      addrs[i] = tcm_pkg::addr_t'(rng[0][30:21]);
      rng[0]   = lcg_next(rng[0]);
      issue(0, 1'b1, addrs[i], 4'hF, rng[0]);
    end
    for (int i = 0; i < 8; i++) issue(0, 1'b0, addrs[i], '0, '0);
    wait_drained();

    // Partial writes on port 1, upper half
    for (int i = 0; i < 8; i++) begin
      rng[1]   = lcg_next(rng[1]);
      addrs[i] = tcm_pkg::addr_t'(HALF) + tcm_pkg::addr_t'(rng[1][30:21]);
      rng[1]   = lcg_next(rng[1]);
      issue(1, 1'b1, addrs[i], 4'hF, rng[1]);
      rng[1]   = lcg_next(rng[1]);
      issue(1, 1'b1, addrs[i], rng[1][19:16], ~rng[1]);
      issue(1, 1'b0, addrs[i], '0, '0);
    end
    wait_drained();

    // Both ports at full rate
    fork
      random_traffic(0);
      random_traffic(1);
    join
    wait_drained();

    // Port 0 write drained, then port 1 reads it
    issue(0, 1'b1, 11'h005, 4'hF, 32'hc0de_5a17);
    while (credits[0] != `TCM_CREDITS) @(negedge CLK);
    issue(1, 1'b0, 11'h005, '0, '0);
    wait_drained();

    $display("all tests passed");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
tcm_pkg.sv
fpga_ram.sv
ct_f_spsram_2048x32.sv
tcm_req_port.sv
tcm_arbiter.sv
tcm_top.sv
tcm_tb.sv
